/* source/legv8_pkg.sv */
`default_nettype none

package legv8_pkg;

  localparam int WORD_W    = 64;
  localparam int INSTR_W   = 32;
  localparam int REG_IDX_W = 5;
  localparam int OPCODE_W  = 11;
  localparam int ALU_FN_W  = 4;
  localparam int NUM_REGS  = 32;
  localparam int DIMM_W    = 9;   // D-type byte offset

  typedef logic [WORD_W-1:0]    word_t;
  typedef logic [INSTR_W-1:0]   instr_t;
  typedef logic [REG_IDX_W-1:0] reg_idx_t;
  typedef logic [OPCODE_W-1:0]  opcode_t;
  typedef logic [ALU_FN_W-1:0]  alu_fn_t;

  // Opcodes, instruction bits 31:21
  localparam opcode_t OPC_ADD  = 11'b100_0101_1000;
  localparam opcode_t OPC_SUB  = 11'b110_0101_1000;
  localparam opcode_t OPC_AND  = 11'b100_0101_0000;
  localparam opcode_t OPC_ORR  = 11'b101_0101_0000;
  localparam opcode_t OPC_LDUR = 11'b111_1100_0010;
  localparam opcode_t OPC_STUR = 11'b111_1100_0000;

  localparam alu_fn_t ALU_AND = 4'b0000;
  localparam alu_fn_t ALU_ORR = 4'b0001;
  localparam alu_fn_t ALU_ADD = 4'b0010;
  localparam alu_fn_t ALU_SUB = 4'b0110;

  localparam reg_idx_t XZR = 5'd31;   // Zero register

  localparam word_t INSTR_BYTES = 64'd4;

endpackage

`default_nettype wire

/* source/fetch_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_unit (
  input  logic              CLOCK,
  input  logic              rst_n,
  input  logic              stall,
  output legv8_pkg::word_t  imem_addr,
  output legv8_pkg::word_t  dec_pc,
  output logic              dec_valid
);
  import legv8_pkg::*;

  word_t next_pc;   // Next sequential fetch

  // Instruction memory answers a cycle late, so a held instruction is fetched again
  assign imem_addr = stall ? dec_pc : next_pc;

  always_ff @(posedge CLOCK) begin
    if (!rst_n) begin
      next_pc   <= '0;
      dec_pc    <= '0;
      dec_valid <= 1'b0;
    end else begin
      next_pc   <= imem_addr + INSTR_BYTES;
      dec_pc    <= imem_addr;   // Tracks imem_data
      dec_valid <= 1'b1;
    end
  end

endmodule

`default_nettype wire

/* source/register_file.sv */
`timescale 1ns/1ps
`default_nettype none

module register_file (
  input  logic                 CLOCK,
  input  logic                 rst_n,
  input  legv8_pkg::reg_idx_t  rd_a,
  input  legv8_pkg::reg_idx_t  rd_b,
  input  legv8_pkg::reg_idx_t  wr_idx,
  input  logic                 wr_en,
  input  legv8_pkg::word_t     wr_data,
  output legv8_pkg::word_t     data_a,
  output legv8_pkg::word_t     data_b
);
  import legv8_pkg::*;

  word_t regs [NUM_REGS];
  logic  wr_live;

  assign wr_live = wr_en && (wr_idx != XZR);   // XZR swallows writes

  always_ff @(posedge CLOCK) begin
    if (!rst_n) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_live) begin
      regs[wr_idx] <= wr_data;
    end
  end

  // Same-cycle write shows up on the read ports
  assign data_a = (rd_a == XZR)                ? '0      :
                  (wr_live && wr_idx == rd_a)  ? wr_data : regs[rd_a];
  assign data_b = (rd_b == XZR)                ? '0      :
                  (wr_live && wr_idx == rd_b)  ? wr_data : regs[rd_b];

endmodule

`default_nettype wire

/* source/decode_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module decode_stage (
  input  logic                 CLOCK,
  input  logic                 rst_n,
  input  legv8_pkg::instr_t    imem_data,
  input  logic                 dec_valid,
  input  legv8_pkg::reg_idx_t  wb_idx,
  input  logic                 wb_en,
  input  legv8_pkg::word_t     wb_data,
  output logic                 stall,
  output legv8_pkg::word_t     ex_a,
  output legv8_pkg::word_t     ex_b,
  output legv8_pkg::word_t     ex_imm,
  output legv8_pkg::reg_idx_t  ex_rn,
  output legv8_pkg::reg_idx_t  ex_rm,
  output legv8_pkg::reg_idx_t  ex_rd,
  output legv8_pkg::alu_fn_t   ex_fn,
  output logic                 ex_use_imm,
  output logic                 ex_mem_read,
  output logic                 ex_mem_write,
  output logic                 ex_reg_write
);
  import legv8_pkg::*;

  opcode_t  opcode;
  reg_idx_t rn;
  reg_idx_t rb;
  reg_idx_t rd;
  word_t    imm;
  word_t    rd_data_a;
  word_t    rd_data_b;
  alu_fn_t  fn;
  logic     use_imm;
  logic     mem_read;
  logic     mem_write;
  logic     reg_write;
  logic     reads_b;
  logic     bubble;

  assign opcode = imem_data[31:21];
  assign rn     = imem_data[9:5];
  assign rd     = imem_data[4:0];
  assign rb     = (opcode == OPC_STUR) ? rd : imem_data[20:16];   // Rt for stores
  assign imm    = {{(WORD_W-DIMM_W){imem_data[12+DIMM_W-1]}}, imem_data[12 +: DIMM_W]};

  always_comb begin
    fn        = ALU_ADD;
    use_imm   = 1'b0;
    mem_read  = 1'b0;
    mem_write = 1'b0;
    reg_write = 1'b0;
    reads_b   = 1'b0;
    case (opcode)
      OPC_ADD, OPC_SUB, OPC_AND, OPC_ORR: begin
        reg_write = 1'b1;
        reads_b   = 1'b1;
        if (opcode == OPC_SUB) fn = ALU_SUB;
        else if (opcode == OPC_AND) fn = ALU_AND;
        else if (opcode == OPC_ORR) fn = ALU_ORR;
      end
      OPC_LDUR: begin
        use_imm   = 1'b1;
        mem_read  = 1'b1;
        reg_write = 1'b1;
      end
      OPC_STUR: begin
        use_imm   = 1'b1;
        mem_write = 1'b1;
        reads_b   = 1'b1;
      end
      default: ;   // Unknown opcode runs as a no-op
    endcase
  end

  // Load in EX whose result the decoded instruction needs next cycle
  assign stall = dec_valid && ex_mem_read && (ex_rd != XZR) &&
                 (((reg_write || mem_write) && ex_rd == rn) || (reads_b && ex_rd == rb));
  assign bubble = stall || !dec_valid;

  register_file u_register_file (
    .CLOCK   (CLOCK),
    .rst_n   (rst_n),
    .rd_a    (rn),
    .rd_b    (rb),
    .wr_idx  (wb_idx),
    .wr_en   (wb_en),
    .wr_data (wb_data),
    .data_a  (rd_data_a),
    .data_b  (rd_data_b)
  );

  always_ff @(posedge CLOCK) begin
    if (!rst_n || bubble) begin
      ex_fn        <= ALU_AND;
      ex_use_imm   <= 1'b0;
      ex_mem_read  <= 1'b0;
      ex_mem_write <= 1'b0;
      ex_reg_write <= 1'b0;
    end else begin
      ex_fn        <= fn;
      ex_use_imm   <= use_imm;
      ex_mem_read  <= mem_read;
      ex_mem_write <= mem_write;
      ex_reg_write <= reg_write;
    end
  end

  always_ff @(posedge CLOCK) begin
    if (!rst_n) begin
      ex_a   <= '0;
      ex_b   <= '0;
      ex_imm <= '0;
      ex_rn  <= '0;
      ex_rm  <= '0;
      ex_rd  <= '0;
    end else begin
      ex_a   <= rd_data_a;
      ex_b   <= rd_data_b;
      ex_imm <= imm;
      ex_rn  <= rn;
      ex_rm  <= rb;
      ex_rd  <= rd;
    end
  end

endmodule

`default_nettype wire

/* source/execute_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module execute_stage (
  input  logic                 CLOCK,
  input  logic                 rst_n,
  input  legv8_pkg::word_t     ex_a,
  input  legv8_pkg::word_t     ex_b,
  input  legv8_pkg::word_t     ex_imm,
  input  legv8_pkg::reg_idx_t  ex_rn,
  input  legv8_pkg::reg_idx_t  ex_rm,
  input  legv8_pkg::reg_idx_t  ex_rd,
  input  legv8_pkg::alu_fn_t   ex_fn,
  input  logic                 ex_use_imm,
  input  logic                 ex_mem_read,
  input  logic                 ex_mem_write,
  input  logic                 ex_reg_write,
  input  legv8_pkg::reg_idx_t  wb_idx,
  input  logic                 wb_en,
  input  legv8_pkg::word_t     wb_data,
  output legv8_pkg::word_t     mem_addr,
  output legv8_pkg::word_t     mem_wdata,
  output logic                 mem_read,
  output logic                 mem_write,
  output legv8_pkg::reg_idx_t  m_rd,
  output logic                 m_reg_write
);
  import legv8_pkg::*;

  word_t src_a;
  word_t src_b;
  word_t opnd_b;
  word_t alu_y;

  // Youngest producer wins, XZR is never forwarded
  function automatic word_t forward(input reg_idx_t src, input word_t reg_val);
    if (m_reg_write && m_rd != XZR && m_rd == src) begin
      return mem_addr;
    end else if (wb_en && wb_idx != XZR && wb_idx == src) begin
      return wb_data;
    end
    return reg_val;
  endfunction

  always_comb begin
    src_a = forward(ex_rn, ex_a);
    src_b = forward(ex_rm, ex_b);
  end

  assign opnd_b = ex_use_imm ? ex_imm : src_b;

  always_comb begin
    case (ex_fn)
      ALU_AND: alu_y = src_a & opnd_b;
      ALU_ORR: alu_y = src_a | opnd_b;
      ALU_ADD: alu_y = src_a + opnd_b;
      ALU_SUB: alu_y = src_a - opnd_b;
      default: alu_y = '0;
    endcase
  end

  always_ff @(posedge CLOCK) begin
    if (!rst_n) begin
      mem_read    <= 1'b0;
      mem_write   <= 1'b0;
      m_reg_write <= 1'b0;
      m_rd        <= '0;
      mem_addr    <= '0;
      mem_wdata   <= '0;
    end else begin
      mem_read    <= ex_mem_read;
      mem_write   <= ex_mem_write;
      m_reg_write <= ex_reg_write;
      m_rd        <= ex_rd;
      mem_addr    <= alu_y;   // Also the data address
      mem_wdata   <= src_b;   // Store data after forwarding
    end
  end

endmodule

`default_nettype wire

/* source/memory_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module memory_stage (
  input  logic                 CLOCK,
  input  logic                 rst_n,
  input  legv8_pkg::word_t     mem_addr,
  input  legv8_pkg::word_t     mem_rdata,
  input  legv8_pkg::reg_idx_t  m_rd,
  input  logic                 m_reg_write,
  input  logic                 mem_read,
  output legv8_pkg::reg_idx_t  wb_idx,
  output logic                 wb_en,
  output legv8_pkg::word_t     wb_data
);
  import legv8_pkg::*;

  word_t wb_result;
  logic  wb_load;

  always_ff @(posedge CLOCK) begin
    if (!rst_n) begin
      wb_en     <= 1'b0;
      wb_load   <= 1'b0;
      wb_idx    <= '0;
      wb_result <= '0;
    end else begin
      wb_en     <= m_reg_write;
      wb_load   <= mem_read;
      wb_idx    <= m_rd;
      wb_result <= mem_addr;
    end
  end

  assign wb_data = wb_load ? mem_rdata : wb_result;   // Load data lands this cycle

endmodule

`default_nettype wire

/* source/legv8_core.sv */
`timescale 1ns/1ps
`default_nettype none

module legv8_core (
  input  logic                CLOCK,
  input  logic                rst_n,
  output legv8_pkg::word_t    imem_addr,
  input  legv8_pkg::instr_t   imem_data,
  output legv8_pkg::word_t    mem_addr,
  output legv8_pkg::word_t    mem_wdata,
  output logic                mem_read,
  output logic                mem_write,
  input  legv8_pkg::word_t    mem_rdata
);
  import legv8_pkg::*;

  logic     stall;
  word_t    dec_pc;     // PC of instruction in decode
  logic     dec_valid;

  word_t    ex_a;
  word_t    ex_b;
  word_t    ex_imm;
  reg_idx_t ex_rn;
  reg_idx_t ex_rm;
  reg_idx_t ex_rd;
  alu_fn_t  ex_fn;
  logic     ex_use_imm;
  logic     ex_mem_read;
  logic     ex_mem_write;
  logic     ex_reg_write;

  reg_idx_t m_rd;
  logic     m_reg_write;

  reg_idx_t wb_idx;
  logic     wb_en;
  word_t    wb_data;

  fetch_unit u_fetch_unit (
    .CLOCK     (CLOCK),
    .rst_n     (rst_n),
    .stall     (stall),
    .imem_addr (imem_addr),
    .dec_pc    (dec_pc),
    .dec_valid (dec_valid)
  );

  decode_stage u_decode_stage (
    .CLOCK        (CLOCK),
    .rst_n        (rst_n),
    .imem_data    (imem_data),
    .dec_valid    (dec_valid),
    .wb_idx       (wb_idx),
    .wb_en        (wb_en),
    .wb_data      (wb_data),
    .stall        (stall),
    .ex_a         (ex_a),
    .ex_b         (ex_b),
    .ex_imm       (ex_imm),
    .ex_rn        (ex_rn),
    .ex_rm        (ex_rm),
    .ex_rd        (ex_rd),
    .ex_fn        (ex_fn),
    .ex_use_imm   (ex_use_imm),
    .ex_mem_read  (ex_mem_read),
    .ex_mem_write (ex_mem_write),
    .ex_reg_write (ex_reg_write)
  );

  execute_stage u_execute_stage (
    .CLOCK        (CLOCK),
    .rst_n        (rst_n),
    .ex_a         (ex_a),
    .ex_b         (ex_b),
    .ex_imm       (ex_imm),
    .ex_rn        (ex_rn),
    .ex_rm        (ex_rm),
    .ex_rd        (ex_rd),
    .ex_fn        (ex_fn),
    .ex_use_imm   (ex_use_imm),
    .ex_mem_read  (ex_mem_read),
    .ex_mem_write (ex_mem_write),
    .ex_reg_write (ex_reg_write),
    .wb_idx       (wb_idx),
    .wb_en        (wb_en),
    .wb_data      (wb_data),
    .mem_addr     (mem_addr),
    .mem_wdata    (mem_wdata),
    .mem_read     (mem_read),
    .mem_write    (mem_write),
    .m_rd         (m_rd),
    .m_reg_write  (m_reg_write)
  );

  memory_stage u_memory_stage (
    .CLOCK       (CLOCK),
    .rst_n       (rst_n),
    .mem_addr    (mem_addr),
    .mem_rdata   (mem_rdata),
    .m_rd        (m_rd),
    .m_reg_write (m_reg_write),
    .mem_read    (mem_read),
    .wb_idx      (wb_idx),
    .wb_en       (wb_en),
    .wb_data     (wb_data)
  );

endmodule

`default_nettype wire

/* testbench/legv8_core_props.sv */
`timescale 1ns/1ps
`default_nettype none

module legv8_core_props (
  input logic             CLOCK,
  input logic             rst_n,
  input legv8_pkg::word_t imem_addr,
  input logic             mem_read,
  input logic             mem_write
);
  import legv8_pkg::*;

  a_one_request: assert property (@(posedge CLOCK) disable iff (!rst_n)
    !(mem_read && mem_write))
    else $error("mem_read and mem_write are high in the same cycle");

  // Reset clears the EX/MEM controls by the next edge
  a_reset_quiet: assert property (@(posedge CLOCK) !rst_n |=> (!mem_read && !mem_write))
    else $error("data request while in reset");

  a_fetch_step: assert property (@(posedge CLOCK) (rst_n && $past(rst_n)) |->
    (imem_addr == $past(imem_addr) || imem_addr == $past(imem_addr) + INSTR_BYTES))
    else $error("fetch address neither held nor advanced by one instruction");

  // Refetch only happens behind a load in EX
  a_refetch_load: assert property (@(posedge CLOCK)
    (rst_n && $past(rst_n) && imem_addr == $past(imem_addr)) |=> mem_read)
    else $error("fetch address repeated without a load request behind it");

endmodule

bind legv8_core legv8_core_props u_legv8_core_props (
  .CLOCK     (CLOCK),
  .rst_n     (rst_n),
  .imem_addr (imem_addr),
  .mem_read  (mem_read),
  .mem_write (mem_write)
);

`default_nettype wire

/* testbench/tb_legv8_core.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_legv8_core;
  import legv8_pkg::*;

  localparam logic [31:0] SEED = 32'hbb1d;
  localparam int PROG_WORDS = 128;
  localparam int PRE_LEN    = 16;     // Loads that seed X0..X15
  localparam int BODY_LEN   = 48;
  localparam int TIMEOUT    = 1000;   // Cycles

  logic   CLOCK     = 1'b0;
  logic   rst_n     = 1'b0;
  instr_t imem_data = '0;
  word_t  mem_rdata = '0;
  word_t  imem_addr;
  word_t  mem_addr;
  word_t  mem_wdata;
  logic   mem_read;
  logic   mem_write;

  instr_t      prog  [PROG_WORDS];
  word_t       dinit [32];
  word_t       dmem  [32];
  word_t       mregs [32];
  word_t       mdmem [32];
  word_t       exp_addr [$];
  word_t       exp_data [$];
  word_t       obs_addr [64];
  word_t       obs_data [64];
  logic [31:0] lfsr_state;
  word_t       prev_addr;
  logic        have_prev   = 1'b0;
  int          n_prog      = 0;
  int          n_obs       = 0;
  int          n_checked   = 0;
  int          repeats     = 0;
  int          exp_repeats = 0;
  int          loads       = 0;
  int          exp_loads   = 0;
  int          value_errs  = 0;
  int          other_errs  = 0;

  legv8_core u_legv8_core (
    .CLOCK     (CLOCK),
    .rst_n     (rst_n),
    .imem_addr (imem_addr),
    .imem_data (imem_data),
    .mem_addr  (mem_addr),
    .mem_wdata (mem_wdata),
    .mem_read  (mem_read),
    .mem_write (mem_write),
    .mem_rdata (mem_rdata)
  );

  always #20 CLOCK = ~CLOCK;

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    if (s[0]) begin
      return (s >> 1) ^ 32'h8020_0003;
    end
    return s >> 1;
  endfunction

  function automatic word_t rand_bits(input int n);
    word_t v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[62:0], lfsr_state[0]};   // One step per bit
      lfsr_state = lfsr_next(lfsr_state);
    end
    return v;
  endfunction

  function automatic instr_t encode_r(input opcode_t opc, input reg_idx_t rm,
                                      input reg_idx_t rn, input reg_idx_t rd);
    return {opc, rm, 6'd0, rn, rd};
  endfunction

  function automatic instr_t encode_d(input opcode_t opc, input logic [8:0] off,
                                      input reg_idx_t rn, input reg_idx_t rt);
    return {opc, off, 2'b00, rn, rt};
  endfunction

  function automatic logic is_alu(input opcode_t opc);
    return opc == OPC_ADD || opc == OPC_SUB || opc == OPC_AND || opc == OPC_ORR;
  endfunction

  function automatic logic reads_reg(input instr_t ins, input reg_idx_t r);
    if (is_alu(ins[31:21])) begin
      return r == ins[9:5] || r == ins[20:16];
    end else if (ins[31:21] == OPC_LDUR) begin
      return r == ins[9:5];
    end else if (ins[31:21] == OPC_STUR) begin
      return r == ins[9:5] || r == ins[4:0];   // Base and Rt
    end
    return 1'b0;
  endfunction

  function automatic word_t model_read(input reg_idx_t r);
    return (r == XZR) ? '0 : mregs[r];
  endfunction

  function automatic instr_t fetch_word(input word_t addr);
    if (addr[63:9] != '0) begin
      return '0;   // No-op past the program
    end
    return prog[addr[8:2]];
  endfunction

  task automatic build_program();
    word_t      r;
    reg_idx_t   rd;
    reg_idx_t   rn;
    reg_idx_t   rm;
    reg_idx_t   prev_rd;
    logic [2:0] kind;
    logic [1:0] op;
    lfsr_state = SEED;
    prev_rd = '0;
    for (int i = 0; i < PROG_WORDS; i++) begin
      prog[i] = '0;
    end
    for (int i = 0; i < 32; i++) begin
      dinit[i] = rand_bits(64);
    end
    for (int i = 0; i < PRE_LEN; i++) begin
      r = rand_bits(5);
      prog[n_prog] = encode_d(OPC_LDUR, {1'b0, r[4:0], 3'b000}, XZR, i[4:0]);
      n_prog = n_prog + 1;
    end
    for (int i = 0; i < BODY_LEN; i++) begin
      r = rand_bits(3);
      kind = r[2:0];
      r = rand_bits(4);
      rd = {1'b0, r[3:0]};
      r = rand_bits(4);
      rn = {1'b0, r[3:0]};
      r = rand_bits(4);
      rm = {1'b0, r[3:0]};
      r = rand_bits(1);
      // Right after the XZR write, XZR is always read back
      if (r[0] || i == 5) begin
        rn = prev_rd;   // Back-to-back dependence
      end
      op = (i < 4) ? i[1:0] : kind[1:0];   // First four cover every ALU function
      if (i == 4) begin
        rd = XZR;
      end
      if (i > 4 && kind < 3'd2) begin
        r = rand_bits(5);
        prog[n_prog] = encode_d(OPC_LDUR, {1'b0, r[4:0], 3'b000}, XZR, rd);
      end else begin
        case (op)
          2'd0: prog[n_prog] = encode_r(OPC_ADD, rm, rn, rd);
          2'd1: prog[n_prog] = encode_r(OPC_SUB, rm, rn, rd);
          2'd2: prog[n_prog] = encode_r(OPC_AND, rm, rn, rd);
          default: prog[n_prog] = encode_r(OPC_ORR, rm, rn, rd);
        endcase
      end
      n_prog = n_prog + 1;
      prev_rd = rd;
    end
    for (int i = 0; i < 32; i++) begin
      prog[n_prog] = encode_d(OPC_STUR, {1'b0, i[4:0], 3'b000}, XZR, i[4:0]);
      n_prog = n_prog + 1;
    end
  endtask

  // In-order ISA model that predicts stores, loads and load-use refetches
  task automatic run_model();
    instr_t   ins;
    opcode_t  opc;
    reg_idx_t rd;
    word_t    a;
    word_t    b;
    word_t    addr;
    word_t    res;
    for (int i = 0; i < 32; i++) begin
      mregs[i] = '0;
      mdmem[i] = dinit[i];
    end
    for (int i = 0; i < n_prog; i++) begin
      ins  = prog[i];
      opc  = ins[31:21];
      rd   = ins[4:0];
      a    = model_read(ins[9:5]);
      b    = model_read(ins[20:16]);
      addr = a + {{55{ins[20]}}, ins[20:12]};
      res  = '0;
      case (opc)
        OPC_ADD:  res = a + b;
        OPC_SUB:  res = a - b;
        OPC_AND:  res = a & b;
        OPC_ORR:  res = a | b;
        OPC_LDUR: res = mdmem[addr[7:3]];
        OPC_STUR: begin
          exp_addr.push_back(addr);
          exp_data.push_back(model_read(rd));
          mdmem[addr[7:3]] = model_read(rd);
        end
        default: ;
      endcase
      if (opc == OPC_LDUR) begin
        exp_loads = exp_loads + 1;
      end
      if ((is_alu(opc) || opc == OPC_LDUR) && rd != XZR) begin
        mregs[rd] = res;
      end
      if (i + 1 < n_prog && opc == OPC_LDUR && rd != XZR && reads_reg(prog[i + 1], rd)) begin
        exp_repeats = exp_repeats + 1;
      end
    end
  endtask

  task automatic check_word(input string what, input word_t got, input word_t exp);
    if (got !== exp) begin
      value_errs = value_errs + 1;
      $display("[FAIL] %0d ns: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_bit(input string what, input logic got, input logic exp);
    if (got !== exp) begin
      value_errs = value_errs + 1;
      $display("[FAIL] %0d ns: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic check_new_stores();
    while (n_checked < n_obs) begin
      if (n_checked < exp_addr.size()) begin
        check_word($sformatf("store %0d address", n_checked), obs_addr[n_checked],
                   exp_addr[n_checked]);
        check_word($sformatf("store %0d data", n_checked), obs_data[n_checked],
                   exp_data[n_checked]);
      end else begin
        other_errs = other_errs + 1;
        $display("Unexpected extra store to address %h", obs_addr[n_checked]);
      end
      n_checked = n_checked + 1;
    end
  endtask

  // Memories answer one cycle after the request
  always @(posedge CLOCK) begin
    if (!rst_n) begin
      imem_data <= '0;
      mem_rdata <= '0;
      for (int i = 0; i < 32; i++) begin
        dmem[i] <= dinit[i];
      end
    end else begin
      imem_data <= fetch_word(imem_addr);
      mem_rdata <= dmem[mem_addr[7:3]];
      if (mem_write) begin
        dmem[mem_addr[7:3]] <= mem_wdata;
        if (n_obs < 64) begin
          obs_addr[n_obs] = mem_addr;
          obs_data[n_obs] = mem_wdata;
          n_obs = n_obs + 1;
        end
      end
    end
  end

  always @(posedge CLOCK) begin
    if (!rst_n) begin
      have_prev = 1'b0;
    end else begin
      if (have_prev && imem_addr == prev_addr) begin
        repeats = repeats + 1;   // Refetch of a held instruction
      end
      if (mem_read) begin
        loads = loads + 1;   // One request per load
      end
      prev_addr = imem_addr;
      have_prev = 1'b1;
    end
  end

  initial begin
    int cycles;
    build_program();
    run_model();
    repeat (3) @(posedge CLOCK);
    rst_n <= 1'b1;
    @(negedge CLOCK);
    check_word("imem_addr after reset", imem_addr, '0);
    check_bit("mem_read after reset", mem_read, 1'b0);
    check_bit("mem_write after reset", mem_write, 1'b0);

    cycles = 0;
    while (n_obs < exp_addr.size() && cycles < TIMEOUT) begin
      @(negedge CLOCK);
      cycles = cycles + 1;
      check_new_stores();
    end
    if (n_obs < exp_addr.size()) begin
      other_errs = other_errs + 1;
      $display("Timeout after %0d cycles: only %0d of %0d stores arrived",
               cycles, n_obs, exp_addr.size());
    end

    cycles = 0;
    while (cycles < 8) begin   // Catch stray stores
      @(negedge CLOCK);
      cycles = cycles + 1;
    end
    check_new_stores();
    if (n_obs >= 32) begin
      check_word("store of X31", obs_data[31], '0);
    end
    check_word("repeated fetch addresses", word_t'(repeats), word_t'(exp_repeats));
    check_word("load requests", word_t'(loads), word_t'(exp_loads));

    $display("Errors: %0d value, %0d other; %0d stores checked, %0d load-use refetches",
             value_errs, other_errs, n_checked, repeats);
    if (value_errs == 0 && other_errs == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* files.f */
source/legv8_pkg.sv
source/fetch_unit.sv
source/register_file.sv
source/decode_stage.sv
source/execute_stage.sv
source/memory_stage.sv
source/legv8_core.sv
testbench/legv8_core_props.sv
testbench/tb_legv8_core.sv

/* Makefile */
TOP := tb_legv8_core

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f files.f -o sim_$(TOP)
	./obj_dir/sim_$(TOP) | tee /dev/stderr | grep -q -F '*** PASSED ***'

clean:
	rm -rf obj_dir

.PHONY: sim clean
